/* rtl/uartPkg.sv */
/*
	UART serial frame definitions
	frame sizes, oversampling tick counts, the payload byte type,
	the baud divisor type and the serializer state encoding
*/

package uartPkg;

	//////////////////////////////
	// frame shape
	//////////////////////////////

	localparam int dataBits    = 8;		// 8N1 payload
	localparam int ticksPerBit = 16;	// oversampling ticks per bit
	localparam int sbTick      = 16;	// ticks in the stop bit, one stop bit

	//////////////////////////////
	// types
	//////////////////////////////

	// one payload byte, LSB goes out first
	typedef logic [dataBits-1:0] dataByte_t;

	// baud divisor, clk cycles per tick
	typedef logic [15:0] divisor_t;

	// serializer FSM states
	typedef enum logic [1:0]
	{
		idle  = 2'b00,	// line high, waiting for a byte
		start = 2'b01,	// start bit, line low
		data  = 2'b10,	// shifting payload bits
		stop  = 2'b11	// stop bit, line high
	} txState_t;

endpackage

/* rtl/fifoPkg.sv */
/*
	transmit buffer and credit definitions
	FIFO depth, pointer/occupancy/credit widths and the host write beat
*/

package fifoPkg;

	//////////////////////////////
	// buffer sizing
	//////////////////////////////

	localparam int fifoDepth = 16;	// entries, also the host credit pool

	typedef logic [3:0] fifoAddr_t;		// read / write pointers, wrap at depth
	typedef logic [4:0] fifoCount_t;	// occupancy 0..16

	// credits held by the host, 0..16
	typedef logic [4:0] credit_t;

	//////////////////////////////
	// host write beat
	//////////////////////////////

	typedef struct packed
	{
		logic             valid;	// spend one credit this cycle
		uartPkg::dataByte_t payload;	// byte to queue
	} hostWrite_t;

endpackage

/* rtl/baudTickGen.sv */
/*
	baud tick generator
	one-cycle oversampling tick every baudDivisor clocks, 0 acts as 1
*/

`timescale 1ns/1ps

module baudTickGen
(
	input  logic              clk,
	input  logic              reset,
	input  uartPkg::divisor_t baudDivisor,	// clocks per tick
	output logic              sTick			// one-cycle tick pulse
);

	import uartPkg::*;

	divisor_t tickCnt;	// down counter, wraps at 0
	divisor_t reload;	// period minus one

	// divisor 0 or 1 gives a tick every clock
	assign reload = (baudDivisor == '0) ? '0 : divisor_t'(baudDivisor - 1'b1);

	// reload only sampled at the wrap, so a new divisor waits for it
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			tickCnt <= '0;
			sTick   <= 1'b0;
		end
		else if (tickCnt == '0)
		begin
			tickCnt <= reload;	// wrap
			sTick   <= 1'b1;
		end
		else
		begin
			tickCnt <= tickCnt - 1'b1;
			sTick   <= 1'b0;
		end
	end

endmodule

/* rtl/txFifo.sv */
/*
	transmit FIFO, 16 entries
	host writes under credit control, serializer pops from the head,
	each pop hands one credit back, writes into a full FIFO are dropped
*/

`timescale 1ns/1ps

module txFifo
(
	input  logic                clk,
	input  logic                reset,
	input  fifoPkg::hostWrite_t hostWr,			// host write beat
	input  logic                pop,			// serializer takes the head
	output uartPkg::dataByte_t  fifoHead,		// oldest byte
	output logic                fifoEmpty,
	output logic                creditReturn,	// one credit back per pop
	output logic                overflowErr		// sticky, write while full
);

	import uartPkg::*;
	import fifoPkg::*;

	dataByte_t  mem [fifoDepth];	// payload storage, no reset
	fifoAddr_t  rdPtr;
	fifoAddr_t  wrPtr;
	fifoCount_t count;				// occupancy

	logic full;
	logic doPop;	// pop that really removes an entry
	logic accept;	// write that really stores

	//////////////////////////////
	// status and handshake
	//////////////////////////////

	assign fifoEmpty = (count == '0);
	assign full      = (count == fifoCount_t'(fifoDepth));

	assign doPop  = pop && !fifoEmpty;				// pop on empty is ignored
	assign accept = hostWr.valid && (!full || doPop);	// full + pop frees a slot

	assign fifoHead     = mem[rdPtr];	// head visible as soon as stored
	assign creditReturn = doPop;		// combinational echo of the pop

	//////////////////////////////
	// storage
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (accept)
			mem[wrPtr] <= hostWr.payload;
	end

	//////////////////////////////
	// pointers and count
	//////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (accept)
				wrPtr <= wrPtr + 1'b1;	// wraps at 16
			if (doPop)
				rdPtr <= rdPtr + 1'b1;

			case ({accept, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

	// overflow flag, held until reset
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			overflowErr <= 1'b0;
		else if (hostWr.valid && !accept)
			overflowErr <= 1'b1;	// dropped write, host broke credit rules
	end

endmodule

/* rtl/uartTrans.sv */
/*
	UART serializer, 8N1
	idle / start / data / stop FSM, pops a byte from the FIFO and
	sends it LSB first, every bit lasting 16 oversampling ticks
*/

`timescale 1ns/1ps

module uartTrans
(
	input  logic               clk,
	input  logic               reset,
	input  logic               sTick,		// oversampling tick
	input  uartPkg::dataByte_t fifoHead,	// byte at FIFO head
	input  logic               fifoEmpty,
	output logic               pop,			// one-cycle FIFO read
	output logic               tx,			// serial line
	output logic               txBusy		// frame in progress
);

	import uartPkg::*;

	txState_t stateReg, stateNext;
	logic [$clog2(ticksPerBit)-1:0] sReg, sNext;	// tick counter inside a bit
	logic [$clog2(dataBits)-1:0]    nReg, nNext;	// data bit index
	dataByte_t bReg, bNext;		// shift register
	logic      txReg, txNext;	// registered line, no glitches

	logic bitEnd;	// last tick of a start or data bit
	logic stopEnd;	// last tick of the stop bit
	logic lastBit;	// shifting the MSB

	assign bitEnd  = sTick && (sReg == ($clog2(ticksPerBit))'(ticksPerBit - 1));
	assign stopEnd = sTick && (sReg == ($clog2(ticksPerBit))'(sbTick - 1));
	assign lastBit = (nReg == ($clog2(dataBits))'(dataBits - 1));

	//////////////////////////////
	// state registers
	//////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= idle;
			sReg     <= '0;
			nReg     <= '0;
			txReg    <= 1'b1;	// line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			txReg    <= txNext;
		end
	end

	// payload register, loaded on pop, no reset
	always_ff @(posedge clk)
	begin
		bReg <= bNext;
	end

	//////////////////////////////
	// next state
	//////////////////////////////

	always_comb
	begin
		stateNext = stateReg;	// hold by default
		sNext     = sReg;
		nNext     = nReg;
		bNext     = bReg;
		txNext    = txReg;

		case (stateReg)
			idle:
			begin
				txNext = 1'b1;
				if (!fifoEmpty)
				begin
					bNext     = fifoHead;	// latch now, head moves after pop
					sNext     = '0;
					txNext    = 1'b0;		// start bit on the next edge
					stateNext = start;
				end
			end

			start:
			begin
				if (bitEnd)
				begin
					sNext     = '0;
					nNext     = '0;
					txNext    = bReg[0];	// first data bit, LSB
					stateNext = data;
				end
				else if (sTick)
					sNext = sReg + 1'b1;
			end

			data:
			begin
				if (bitEnd)
				begin
					sNext = '0;
					bNext = bReg >> 1;	// next bit into position 0
					if (lastBit)
					begin
						txNext    = 1'b1;	// stop bit
						stateNext = stop;
					end
					else
					begin
						nNext  = nReg + 1'b1;
						txNext = bReg[1];
					end
				end
				else if (sTick)
					sNext = sReg + 1'b1;
			end

			stop:
			begin
				if (stopEnd)
				begin
					sNext     = '0;
					stateNext = idle;	// may pop again right away
				end
				else if (sTick)
					sNext = sReg + 1'b1;
			end

			default: stateNext = idle;
		endcase
	end

	//////////////////////////////
	// outputs
	//////////////////////////////

	assign pop    = (stateReg == idle) && !fifoEmpty;	// same cycle as the latch
	assign tx     = txReg;
	assign txBusy = (stateReg != idle);

endmodule

/* rtl/uartTxTop.sv */
/*
	UART transmit subsystem
	baud tick generator, credit-controlled transmit FIFO and serializer
*/

`timescale 1ns/1ps

module uartTxTop
(
	input  logic                clk,
	input  logic                reset,
	input  uartPkg::divisor_t   baudDivisor,	// clocks per oversampling tick
	input  fifoPkg::hostWrite_t hostWr,			// host write beat
	output logic                creditReturn,	// one credit per popped byte
	output logic                overflowErr,	// sticky
	output logic                tx,				// serial out
	output logic                txBusy
);

	import uartPkg::*;

	logic      sTick;		// tick generator to serializer
	dataByte_t fifoHead;	// FIFO head byte
	logic      fifoEmpty;
	logic      pop;			// serializer read strobe

	//////////////////////////////
	// tick generator
	//////////////////////////////

	baudTickGen uBaud
	(
		.clk         (clk),
		.reset       (reset),
		.baudDivisor (baudDivisor),
		.sTick       (sTick)
	);

	//////////////////////////////
	// transmit FIFO
	//////////////////////////////

	txFifo uFifo
	(
		.clk          (clk),
		.reset        (reset),
		.hostWr       (hostWr),
		.pop          (pop),
		.fifoHead     (fifoHead),
		.fifoEmpty    (fifoEmpty),
		.creditReturn (creditReturn),	// pop echoed back to the host
		.overflowErr  (overflowErr)
	);

	//////////////////////////////
	// serializer
	//////////////////////////////

	uartTrans uTrans
	(
		.clk       (clk),
		.reset     (reset),
		.sTick     (sTick),
		.fifoHead  (fifoHead),
		.fifoEmpty (fifoEmpty),
		.pop       (pop),
		.tx        (tx),
		.txBusy    (txBusy)
	);

endmodule

/* test/uartTxProps.sv */
/*
	serializer properties
	pop handshake, line level per FSM state, idle left only by a pop
*/

`timescale 1ns/1ps

module uartTxProps
(
	input logic              clk,
	input logic              reset,
	input uartPkg::txState_t state,		// serializer FSM state
	input logic              pop,
	input logic              fifoEmpty,
	input logic              tx
);

	import uartPkg::*;

	//////////////////////////////
	// FIFO handshake
	//////////////////////////////

	// pop only from idle with data waiting, start bit on the next edge
	popLegal: assert property (@(posedge clk) disable iff (reset)
		pop |-> (!fifoEmpty && state == idle) ##1 (state == start))
		else $error("pop not from idle with data waiting, or no start state after it");

	popPulse: assert property (@(posedge clk) disable iff (reset) pop |=> !pop)
		else $error("pop held for more than one cycle");	// start follows a pop

	//////////////////////////////
	// line level
	//////////////////////////////

	lineHigh: assert property (@(posedge clk) disable iff (reset)
		(state == idle || state == stop) |-> tx)
		else $error("tx low in idle or stop");

	lineStart: assert property (@(posedge clk) disable iff (reset) (state == start) |-> !tx)
		else $error("tx high during the start bit");

	// no frame without a byte
	idleExit: assert property (@(posedge clk) disable iff (reset)
		(state == idle && !pop) |=> (state == idle))
		else $error("serializer left idle without a pop");

endmodule

/* test/uartTxTb.sv */
/*
	UART transmit subsystem testbench
	random host traffic under credit rules, a serial decoder on tx
	and a byte queue model that every decoded frame is checked against
*/

`timescale 1ns/1ps

module uartTxTb;

	import uartPkg::*;
	import fifoPkg::*;

	localparam int baudDiv     = 4;
	localparam int bitClocks   = ticksPerBit * baudDiv;		// 64 clocks per bit
	localparam int frameClocks = (dataBits + 2) * bitClocks;	// start + data + stop
	localparam int burstLen    = 40;
	localparam int gapLen      = 8;
	localparam int overflowLen = 20;
	localparam int timeoutCycles =
		(1 + burstLen + gapLen + overflowLen) * frameClocks + 3000;	// all frames + margin

	logic       clk;
	logic       reset;
	divisor_t   baudDivisor;
	hostWrite_t hostWr;
	logic       creditReturn;
	logic       overflowErr;
	logic       tx;
	logic       txBusy;

	int        seed = 32'h18c1_3c8a;
	dataByte_t modelQ[$];		// accepted bytes not yet seen on the line
	credit_t   credits;			// host credit pool
	int        creditPulses = 0;
	int        framesDecoded = 0;
	int        accepted = 0;
	int        dropped = 0;
	int        errorCount = 0;
	int        testErrors = 0;
	int        testsFailed = 0;
	int        cycleCount = 0;
	string     curTest;
	logic      prevTx;

	uartTxTop DUT
	(
		.clk          (clk),
		.reset        (reset),
		.baudDivisor  (baudDivisor),
		.hostWr       (hostWr),
		.creditReturn (creditReturn),
		.overflowErr  (overflowErr),
		.tx           (tx),
		.txBusy       (txBusy)
	);

	bind uartTrans uartTxProps uProps
	(
		.clk       (clk),
		.reset     (reset),
		.state     (stateReg),
		.pop       (pop),
		.fifoEmpty (fifoEmpty),
		.tx        (tx)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;	// 20 ns period
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic noteError();
		errorCount++;
		testErrors++;
	endtask

	function automatic dataByte_t randomByte();
		return dataByte_t'($random(seed));
	endfunction

	// falling edge, collect the returned credit, release the write beat
	task automatic nextCycle();
		@(negedge clk);
		hostWr = '0;
		if (creditReturn)
		begin
			credits++;
			creditPulses++;
		end
		assert (credits <= credit_t'(fifoDepth))
		else
		begin
			$display("%s: host holds %0d credits, more than the FIFO depth", curTest, credits);
			noteError();
		end
	endtask

	// drive one write beat, accepted only if a credit backs it
	task automatic writeByte(input dataByte_t b);
		hostWr.valid   = 1'b1;
		hostWr.payload = b;
		if (credits > 0)
		begin
			credits--;
			accepted++;
			modelQ.push_back(b);
		end
		else
			dropped++;	// FIFO full, DUT drops it
	endtask

	task automatic waitDrain();
		nextCycle();
		while (modelQ.size() != 0 || txBusy)
			nextCycle();
		repeat (2) nextCycle();
	endtask

	task automatic beginTest(input string name);
		curTest    = name;
		testErrors = 0;
	endtask

	task automatic endTest();
		if (testErrors == 0)
			$display("test %s: ok", curTest);
		else
		begin
			$display("test %s: %0d errors", curTest, testErrors);
			testsFailed++;
		end
	endtask

	//////////////////////////////
	// serial decoder
	//////////////////////////////

	// three samples per bit, early / middle / late, middle one is the value
	task automatic decodeFrame();
		logic [9:0] frame;
		logic       early;
		logic       mid;
		logic       late;
		dataByte_t  expected;
		for (int i = 0; i < dataBits + 2; i++)
		begin
			repeat (bitClocks / 8) @(negedge clk);
			early = tx;
			repeat (bitClocks * 3 / 8) @(negedge clk);
			mid = tx;
			repeat (bitClocks * 3 / 8) @(negedge clk);
			late = tx;
			if (i < dataBits + 1)
				repeat (bitClocks / 8) @(negedge clk);	// stop bit ends early, next start may follow
			frame[i] = mid;
			assert (early == mid && mid == late)
			else
			begin
				$display("%s: bit %0d not stable over its %0d clocks", curTest, i, bitClocks);
				noteError();
			end
		end
		framesDecoded++;
		assert (frame[0] == 1'b0)
		else
		begin
			$display("CHECK FAILED %s: start bit expected 0 actual %b", curTest, frame[0]);
			noteError();
		end
		assert (frame[9] == 1'b1)
		else
		begin
			$display("CHECK FAILED %s: stop bit expected 1 actual %b", curTest, frame[9]);
			noteError();
		end
		if (modelQ.size() == 0)
		begin
			$display("%s: frame on tx with no byte queued in the model", curTest);
			noteError();
		end
		else
		begin
			expected = modelQ.pop_front();
			assert (frame[8:1] == expected)
			else
			begin
				$display("CHECK FAILED %s: byte expected %h actual %h", curTest, expected, frame[8:1]);
				noteError();
			end
		end
	endtask

	initial
	begin
		prevTx = 1'b1;
		forever
		begin
			@(negedge clk);
			if (!reset && prevTx && !tx)
				decodeFrame();	// returns late in the stop bit
			prevTx = tx;
		end
	end

	// run limit
	initial
	begin
		while (cycleCount < timeoutCycles)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout after %0d cycles, traffic never drained", cycleCount);
		$display(">>> FAIL");
		$finish;
	end

	//////////////////////////////
	// tests
	//////////////////////////////

	initial
	begin
		int framesBefore;
		int pulsesBefore;
		int burstPulses;
		int sent;
		int gap;
		reset       = 1'b1;
		baudDivisor = divisor_t'(baudDiv);
		hostWr      = '0;
		credits     = credit_t'(fifoDepth);	// one credit per entry
		repeat (3) @(negedge clk);
		reset = 1'b0;

		beginTest("idle line");
		repeat (100)
		begin
			nextCycle();
			assert (tx && !txBusy && !creditReturn && !overflowErr)
			else
			begin
				$display("CHECK FAILED %s: tx,busy,credit,overflow expected 1000 actual %b%b%b%b",
					curTest, tx, txBusy, creditReturn, overflowErr);
				noteError();
			end
		end
		endTest();

		beginTest("single frame");
		nextCycle();
		writeByte(randomByte());
		waitDrain();
		assert (framesDecoded == 1)
		else
		begin
			$display("CHECK FAILED %s: frames expected 1 actual %0d", curTest, framesDecoded);
			noteError();
		end
		endTest();

		beginTest("burst ordering");
		framesBefore = framesDecoded;
		sent = 0;
		while (sent < burstLen)
		begin
			nextCycle();
			if (credits > 0)
			begin
				writeByte(randomByte());
				sent++;
			end
		end
		waitDrain();
		assert (framesDecoded - framesBefore == burstLen)
		else
		begin
			$display("CHECK FAILED %s: frames expected %0d actual %0d",
				curTest, burstLen, framesDecoded - framesBefore);
			noteError();
		end
		endTest();

		beginTest("credit accounting");
		for (int i = 0; i < gapLen; i++)
		begin
			gap = $random(seed) & 32'h3f;
			repeat (gap) nextCycle();
			nextCycle();
			while (credits == 0)
				nextCycle();
			writeByte(randomByte());
		end
		waitDrain();
		assert (creditPulses == framesDecoded)
		else
		begin
			$display("CHECK FAILED %s: credit pulses expected %0d actual %0d",
				curTest, framesDecoded, creditPulses);
			noteError();
		end
		assert (credits == credit_t'(fifoDepth))
		else
		begin
			$display("CHECK FAILED %s: credits expected %0d actual %0d",
				curTest, fifoDepth, credits);
			noteError();
		end
		// no overflow from a host that kept to its credits
		assert (!overflowErr)
		else
		begin
			$display("CHECK FAILED %s: overflowErr expected 0 actual %b", curTest, overflowErr);
			noteError();
		end
		endTest();

		// host ignores credits here on purpose
		beginTest("overflow");
		framesBefore = framesDecoded;
		pulsesBefore = creditPulses;
		accepted     = 0;
		dropped      = 0;
		repeat (overflowLen)
		begin
			nextCycle();
			writeByte(randomByte());
		end
		burstPulses = creditPulses - pulsesBefore;
		nextCycle();
		assert (overflowErr)
		else
		begin
			$display("CHECK FAILED %s: overflowErr expected 1 actual %b after %0d dropped writes",
				curTest, overflowErr, dropped);
			noteError();
		end
		assert (accepted == fifoDepth + burstPulses)
		else
		begin
			$display("CHECK FAILED %s: accepted expected %0d actual %0d",
				curTest, fifoDepth + burstPulses, accepted);
			noteError();
		end
		waitDrain();
		assert (framesDecoded - framesBefore == accepted)
		else
		begin
			$display("CHECK FAILED %s: frames expected %0d actual %0d",
				curTest, accepted, framesDecoded - framesBefore);
			noteError();
		end
		assert (credits == credit_t'(fifoDepth))
		else
		begin
			$display("CHECK FAILED %s: credits expected %0d actual %0d",
				curTest, fifoDepth, credits);
			noteError();
		end
		endTest();

		$display("totals: 5 tests, %0d failed, %0d errors", testsFailed, errorCount);
		if (errorCount == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* verilog.f */
rtl/uartPkg.sv
rtl/fifoPkg.sv
rtl/baudTickGen.sv
rtl/txFifo.sv
rtl/uartTrans.sv
rtl/uartTxTop.sv
test/uartTxProps.sv
test/uartTxTb.sv

/* Makefile */
# Verilator simulation of the UART transmit subsystem
# every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= uartTxTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= >>> PASS
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# build, run, then decide the result from the log
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF -- '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
